// File: hdl/mini_core_config.svh
// Width and size constants for the mini_core RTL, included by every design file that needs them
`ifndef MINI_CORE_CONFIG_SVH
`define MINI_CORE_CONFIG_SVH

// data path and instruction word width
`define CORE_DATA_WIDTH 32

// register file addressing
`define CORE_REG_ADDR_WIDTH 5
`define CORE_REG_COUNT 32

`endif

// File: hdl/mini_core_pkg.sv
// Shared encodings for mini_core, imported by the RTL and by the checker for decoding
package mini_core_pkg;

  // major opcode, instruction bits 30 to 25
  typedef enum logic [5:0] {
    OP_ALU  = 6'b100000,
    OP_MOVI = 6'b100010,
    OP_ADDI = 6'b101000,
    OP_XORI = 6'b101011,
    OP_ORI  = 6'b101100
  } opcode_t;

  // ALU group function, instruction bits 4 to 0
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } sub_opcode_t;

  typedef enum logic [1:0] {
    STATE_STOP      = 2'b00,
    STATE_FETCH     = 2'b01,
    STATE_EXECUTE   = 2'b10,
    STATE_WRITEBACK = 2'b11
  } core_state_t;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_form_t;

  // nine operations, so four bits
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_ROR    = 4'd7,
    ALU_PASS_B = 4'd8
  } alu_func_t;

endpackage

// File: hdl/core_controller.sv
// Stop, fetch, execute and writeback sequencer with instruction register and decoder for mini_core
`timescale 1ns/1ps
`include "mini_core_config.svh"

module core_controller
  import mini_core_pkg::*;
(
  input  logic                            clock,
  input  logic                            reset,
  input  logic [`CORE_DATA_WIDTH-1:0]     instruction,
  output logic                            fetch_strobe,
  output logic                            execute_strobe,
  output logic                            write_enable,
  output logic [`CORE_REG_ADDR_WIDTH-1:0] read_address_a,
  output logic [`CORE_REG_ADDR_WIDTH-1:0] read_address_b,
  output logic [`CORE_REG_ADDR_WIDTH-1:0] write_address,
  output alu_func_t                       alu_func,
  output imm_form_t                       imm_form,
  output logic                            use_immediate,
  output logic [`CORE_DATA_WIDTH-1:0]     latched_instruction
);

  core_state_t                 state;
  core_state_t                 next_state;
  logic [`CORE_DATA_WIDTH-1:0] instruction_reg;
  logic [`CORE_DATA_WIDTH-1:0] decode_word;
  opcode_t                     opcode;
  sub_opcode_t                 sub_opcode;
  logic                        writes_register;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= STATE_STOP;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_strobe) begin
      instruction_reg <= instruction;
    end
  end

  assign fetch_strobe   = (state == STATE_FETCH);
  assign execute_strobe = (state == STATE_EXECUTE);
  assign write_enable   = (state == STATE_WRITEBACK) && writes_register;

  // while fetching, decode straight from the bus so MOVI can skip execute
  assign decode_word         = fetch_strobe ? instruction : instruction_reg;
  assign latched_instruction = decode_word;

  assign opcode         = opcode_t'(decode_word[30:25]);
  assign sub_opcode     = sub_opcode_t'(decode_word[4:0]);
  assign read_address_a = decode_word[19:15];
  assign read_address_b = decode_word[14:10];
  assign write_address  = decode_word[24:20];

  always_comb begin
    case (state)
      STATE_STOP:      next_state = STATE_FETCH;
      STATE_FETCH:     next_state = (opcode == OP_MOVI) ? STATE_WRITEBACK : STATE_EXECUTE;
      STATE_EXECUTE:   next_state = STATE_WRITEBACK;
      STATE_WRITEBACK: next_state = STATE_STOP;
      default:         next_state = STATE_STOP;
    endcase
  end

  always_comb begin
    alu_func        = ALU_ADD;
    imm_form        = IMM5_ZE;
    use_immediate   = 1'b0;
    writes_register = 1'b1;
    case (opcode)
      OP_ALU: begin
        case (sub_opcode)
          ADD:   alu_func = ALU_ADD;
          SUB:   alu_func = ALU_SUB;
          AND:   alu_func = ALU_AND;
          XOR:   alu_func = ALU_XOR;
          OR:    alu_func = ALU_OR;
          SLLI: begin
            alu_func      = ALU_SLL;
            use_immediate = 1'b1;
          end
          SRLI: begin
            alu_func      = ALU_SRL;
            use_immediate = 1'b1;
          end
          ROTRI: begin
            alu_func      = ALU_ROR;
            use_immediate = 1'b1;
          end
          default: writes_register = 1'b0;
        endcase
      end
      OP_ADDI: begin
        imm_form      = IMM15_SE;
        use_immediate = 1'b1;
      end
      OP_ORI: begin
        alu_func      = ALU_OR;
        imm_form      = IMM15_ZE;
        use_immediate = 1'b1;
      end
      OP_XORI: begin
        alu_func      = ALU_XOR;
        imm_form      = IMM15_ZE;
        use_immediate = 1'b1;
      end
      OP_MOVI: begin
        alu_func      = ALU_PASS_B;
        imm_form      = IMM20_SE;
        use_immediate = 1'b1;
      end
      default: writes_register = 1'b0;
    endcase
  end

  // write right after fetch for MOVI, right after execute for all others
  write_in_writeback: assert property (@(posedge clock) disable iff (reset)
    write_enable |-> ((opcode == OP_MOVI) ? $past(fetch_strobe) : $past(execute_strobe)));

  stop_then_fetch: assert property (@(posedge clock) disable iff (reset)
    state == STATE_STOP |=> state == STATE_FETCH);

endmodule

// File: hdl/register_file.sv
// Register file for mini_core with two combinational read ports and one synchronous write port
`timescale 1ns/1ps
`include "mini_core_config.svh"

module register_file (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            write_enable,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] read_address_a,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] read_address_b,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] write_address,
  input  logic [`CORE_DATA_WIDTH-1:0]     write_data,
  output logic [`CORE_DATA_WIDTH-1:0]     read_data_a,
  output logic [`CORE_DATA_WIDTH-1:0]     read_data_b
);

  logic [`CORE_DATA_WIDTH-1:0] registers [`CORE_REG_COUNT];

  // register 0 is writable like any other
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        registers[i] <= '0;
      end
    end else if (write_enable) begin
      registers[write_address] <= write_data;
    end
  end

  assign read_data_a = registers[read_address_a];
  assign read_data_b = registers[read_address_b];

  // destination comes from the controller's instruction register
  write_address_known: assert property (@(posedge clock) disable iff (reset)
    write_enable |-> !$isunknown(write_address));

endmodule

// File: hdl/alu.sv
// Combinational arithmetic, logic, shift and rotate unit of mini_core
`timescale 1ns/1ps
`include "mini_core_config.svh"

module alu
  import mini_core_pkg::*;
(
  input  alu_func_t                   alu_func,
  input  logic [`CORE_DATA_WIDTH-1:0] operand_a,
  input  logic [`CORE_DATA_WIDTH-1:0] operand_b,
  output logic [`CORE_DATA_WIDTH-1:0] result
);

  logic [4:0]                    shift_amount;
  logic [2*`CORE_DATA_WIDTH-1:0] rotate_wide;

  assign shift_amount = operand_b[4:0];

  // doubled word shifted right leaves the rotation in the low half
  assign rotate_wide = {operand_a, operand_a} >> shift_amount;

  always_comb begin
    case (alu_func)
      ALU_ADD:    result = operand_a + operand_b;
      ALU_SUB:    result = operand_a - operand_b;
      ALU_AND:    result = operand_a & operand_b;
      ALU_OR:     result = operand_a | operand_b;
      ALU_XOR:    result = operand_a ^ operand_b;
      ALU_SLL:    result = operand_a << shift_amount;
      ALU_SRL:    result = operand_a >> shift_amount;
      ALU_ROR:    result = rotate_wide[`CORE_DATA_WIDTH-1:0];
      ALU_PASS_B: result = operand_b;
      default:    result = '0;
    endcase
  end

endmodule

// File: hdl/operand_select.sv
// Immediate extraction and extension, and the register or immediate choice for ALU operand b
`timescale 1ns/1ps
`include "mini_core_config.svh"

module operand_select
  import mini_core_pkg::*;
(
  input  logic [`CORE_DATA_WIDTH-1:0] instruction,
  input  imm_form_t                   imm_form,
  input  logic                        use_immediate,
  input  logic [`CORE_DATA_WIDTH-1:0] read_data_b,
  output logic [`CORE_DATA_WIDTH-1:0] operand_b
);

  logic [`CORE_DATA_WIDTH-1:0] immediate;

  always_comb begin
    case (imm_form)
      IMM5_ZE:  immediate = {{(`CORE_DATA_WIDTH-5){1'b0}}, instruction[14:10]};
      IMM15_SE: immediate = {{(`CORE_DATA_WIDTH-15){instruction[14]}}, instruction[14:0]};
      IMM15_ZE: immediate = {{(`CORE_DATA_WIDTH-15){1'b0}}, instruction[14:0]};
      IMM20_SE: immediate = {{(`CORE_DATA_WIDTH-20){instruction[19]}}, instruction[19:0]};
      default:  immediate = '0;
    endcase
  end

  assign operand_b = use_immediate ? immediate : read_data_b;

endmodule

// File: hdl/mini_core.sv
// Top level of the multi-cycle mini_core, with the program counter and the execute result register
`timescale 1ns/1ps
`include "mini_core_config.svh"

module mini_core
  import mini_core_pkg::*;
(
  input  logic                            clock,
  input  logic                            reset,
  input  logic [`CORE_DATA_WIDTH-1:0]     instruction,
  output logic [`CORE_DATA_WIDTH-1:0]     pc,
  output logic                            fetch_strobe,
  output logic                            writeback_strobe,
  output logic [`CORE_REG_ADDR_WIDTH-1:0] writeback_address,
  output logic [`CORE_DATA_WIDTH-1:0]     writeback_data
);

  logic                            execute_strobe;
  logic                            write_enable;
  logic [`CORE_REG_ADDR_WIDTH-1:0] read_address_a;
  logic [`CORE_REG_ADDR_WIDTH-1:0] read_address_b;
  logic [`CORE_REG_ADDR_WIDTH-1:0] write_address;
  alu_func_t                       alu_func;
  imm_form_t                       imm_form;
  logic                            use_immediate;
  logic [`CORE_DATA_WIDTH-1:0]     latched_instruction;
  logic [`CORE_DATA_WIDTH-1:0]     read_data_a;
  logic [`CORE_DATA_WIDTH-1:0]     read_data_b;
  logic [`CORE_DATA_WIDTH-1:0]     operand_b;
  logic [`CORE_DATA_WIDTH-1:0]     result;
  logic [`CORE_DATA_WIDTH-1:0]     result_reg;
  logic                            load_result;
  logic                            load_result_q;
  logic                            writeback_cycle;

  core_controller controller (
    .clock               (clock),
    .reset               (reset),
    .instruction         (instruction),
    .fetch_strobe        (fetch_strobe),
    .execute_strobe      (execute_strobe),
    .write_enable        (write_enable),
    .read_address_a      (read_address_a),
    .read_address_b      (read_address_b),
    .write_address       (write_address),
    .alu_func            (alu_func),
    .imm_form            (imm_form),
    .use_immediate       (use_immediate),
    .latched_instruction (latched_instruction)
  );

  register_file registers (
    .clock          (clock),
    .reset          (reset),
    .write_enable   (write_enable),
    .read_address_a (read_address_a),
    .read_address_b (read_address_b),
    .write_address  (write_address),
    .write_data     (result_reg),
    .read_data_a    (read_data_a),
    .read_data_b    (read_data_b)
  );

  operand_select operands (
    .instruction   (latched_instruction),
    .imm_form      (imm_form),
    .use_immediate (use_immediate),
    .read_data_b   (read_data_b),
    .operand_b     (operand_b)
  );

  alu alu_unit (
    .alu_func  (alu_func),
    .operand_a (read_data_a),
    .operand_b (operand_b),
    .result    (result)
  );

  // writeback always follows an execute cycle, or a fetch for MOVI
  assign load_result     = fetch_strobe || execute_strobe;
  assign writeback_cycle = load_result_q && !load_result;

  always_ff @(posedge clock) begin
    if (load_result) begin
      result_reg <= result;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      load_result_q <= 1'b0;
      pc            <= '0;
    end else begin
      load_result_q <= load_result;
      // advance even when the instruction writes nothing
      if (writeback_cycle) begin
        pc <= pc + `CORE_DATA_WIDTH'd4;
      end
    end
  end

  assign writeback_strobe  = write_enable;
  assign writeback_address = write_address;
  assign writeback_data    = result_reg;

endmodule

// File: verif/mini_core_checker.sv
// Watches the mini_core ports, predicts every register write from the ISA and compares it
`timescale 1ns/1ps
`include "mini_core_config.svh"

module mini_core_checker
  import mini_core_pkg::*;
(
  input  logic                            clock,
  input  logic                            reset,
  input  logic [`CORE_DATA_WIDTH-1:0]     instruction,
  input  logic [`CORE_DATA_WIDTH-1:0]     pc,
  input  logic                            fetch_strobe,
  input  logic                            writeback_strobe,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] writeback_address,
  input  logic [`CORE_DATA_WIDTH-1:0]     writeback_data,
  input  logic                            phase_done,
  input  logic [2:0]                      phase_index,
  output int                              total_checks,
  output int                              total_errors
);

  logic [31:0] model_regs [32];
  logic [31:0] expected_pc;
  logic [31:0] expected_value;
  logic [4:0]  expected_dest;
  logic        expect_write;
  logic        pending;
  logic        check_idle;
  int          expected_latency;
  int          cycles;
  int          current_phase;
  int          phase_checks;
  int          phase_errors;

  function automatic string phase_name(input int index);
    case (index)
      0:       return "movi setup";
      1:       return "register alu";
      2:       return "immediate alu";
      3:       return "shift and rotate";
      4:       return "random mix";
      default: return "after program";
    endcase
  endfunction

  // decode by the ISA and update the model, returns whether a write happens
  function automatic logic predict_write(input logic [31:0] word, output logic [4:0] dest,
                                         output logic [31:0] value);
    logic [31:0] a;
    logic [31:0] b;
    logic [5:0]  amount;
    logic        writes;
    a      = model_regs[word[19:15]];
    b      = model_regs[word[14:10]];
    amount = {1'b0, word[14:10]};
    dest   = word[24:20];
    value  = '0;
    writes = 1'b1;
    case (opcode_t'(word[30:25]))
      OP_ALU: begin
        case (sub_opcode_t'(word[4:0]))
          ADD:     value = a + b;
          SUB:     value = a - b;
          AND:     value = a & b;
          XOR:     value = a ^ b;
          OR:      value = a | b;
          SLLI:    value = a << amount;
          SRLI:    value = a >> amount;
          ROTRI:   value = (a >> amount) | (a << (6'd32 - amount));
          default: writes = 1'b0;
        endcase
      end
      OP_ADDI: value = a + {{17{word[14]}}, word[14:0]};
      OP_ORI:  value = a | {17'd0, word[14:0]};
      OP_XORI: value = a ^ {17'd0, word[14:0]};
      OP_MOVI: value = {{12{word[19]}}, word[19:0]};
      default: writes = 1'b0;
    endcase
    if (writes) begin
      model_regs[dest] = value;
    end
    return writes;
  endfunction

  task automatic require_true(input logic condition, input string text);
    phase_checks = phase_checks + 1;
    total_checks = total_checks + 1;
    if (!condition) begin
      phase_errors = phase_errors + 1;
      total_errors = total_errors + 1;
      $display("error in %s: %s", phase_name(current_phase), text);
    end
  endtask

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    phase_checks = phase_checks + 1;
    total_checks = total_checks + 1;
    if (actual !== expected) begin
      phase_errors = phase_errors + 1;
      total_errors = total_errors + 1;
      $display("mismatch in %s: %s expected %h, actual %h", phase_name(current_phase), what,
               expected, actual);
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      expected_pc   = '0;
      pending       = 1'b0;
      expect_write  = 1'b0;
      check_idle    = 1'b1;
      cycles        = 0;
      current_phase = 0;
      phase_checks  = 0;
      phase_errors  = 0;
      total_checks  = 0;
      total_errors  = 0;
    end else begin
      // close the finished phase before anything of the next one is counted
      if (phase_done) begin
        $display("phase %0d %s: %0d checks, %0d errors", phase_index,
                 phase_name(int'(phase_index)), phase_checks, phase_errors);
        current_phase = int'(phase_index) + 1;
        phase_checks  = 0;
        phase_errors  = 0;
      end
      if (check_idle) begin
        require_true(pc == '0 && !fetch_strobe && !writeback_strobe,
                     "core is not idle with pc zero after reset");
        check_idle = 1'b0;
      end
      if (fetch_strobe) begin
        require_true(!(pending && expect_write),
                     $sformatf("no register write to r%0d before the fetch at pc %h",
                               expected_dest, pc));
        compare_value("pc", expected_pc, pc);
        expected_pc      = expected_pc + 32'd4;
        expect_write     = predict_write(instruction, expected_dest, expected_value);
        expected_latency = (opcode_t'(instruction[30:25]) == OP_MOVI) ? 1 : 2;
        pending          = 1'b1;
        cycles           = 0;
      end else begin
        cycles = cycles + 1;
      end
      if (writeback_strobe) begin
        require_true(pending && expect_write,
                     $sformatf("unexpected register write to r%0d", writeback_address));
        if (pending && expect_write) begin
          require_true(cycles == expected_latency,
                       $sformatf("register write came %0d cycles after fetch, expected %0d",
                                 cycles, expected_latency));
          compare_value("write address", 32'(expected_dest), 32'(writeback_address));
          compare_value("write data", expected_value, writeback_data);
          expect_write = 1'b0;
        end
      end
    end
  end

endmodule

// File: verif/mini_core_tb.sv
// Testbench top for mini_core, builds a random program, feeds instructions and reports the outcome
`timescale 1ns/1ps
`include "mini_core_config.svh"

module mini_core_tb
  import mini_core_pkg::*;
();

  localparam int          PROGRAM_WORDS = 256;
  localparam int          CLOCK_PERIOD  = 10;
  localparam int          RESET_CYCLES  = 10;
  localparam int          PHASE_COUNT   = 5;
  localparam logic [31:0] LFSR_SEED     = 32'hefae;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS     = 32'h80200003;
  // at most four cycles per instruction, plus reset and some slack
  localparam int          WATCHDOG_NS   = (PROGRAM_WORDS * 4 + RESET_CYCLES + 100) * CLOCK_PERIOD;

  logic                            clock = 1'b0;
  logic                            reset;
  logic [`CORE_DATA_WIDTH-1:0]     instruction = '0;
  logic [`CORE_DATA_WIDTH-1:0]     pc;
  logic                            fetch_strobe;
  logic                            writeback_strobe;
  logic [`CORE_REG_ADDR_WIDTH-1:0] writeback_address;
  logic [`CORE_DATA_WIDTH-1:0]     writeback_data;
  logic                            phase_done;
  logic [2:0]                      phase_index;
  int                              total_checks;
  int                              total_errors;
  logic [31:0]                     program_words [PROGRAM_WORDS];
  logic [31:0]                     lfsr_state;

  mini_core dut (
    .clock             (clock),
    .reset             (reset),
    .instruction       (instruction),
    .pc                (pc),
    .fetch_strobe      (fetch_strobe),
    .writeback_strobe  (writeback_strobe),
    .writeback_address (writeback_address),
    .writeback_data    (writeback_data)
  );

  mini_core_checker write_checker (
    .clock             (clock),
    .reset             (reset),
    .instruction       (instruction),
    .pc                (pc),
    .fetch_strobe      (fetch_strobe),
    .writeback_strobe  (writeback_strobe),
    .writeback_address (writeback_address),
    .writeback_data    (writeback_data),
    .phase_done        (phase_done),
    .phase_index       (phase_index),
    .total_checks      (total_checks),
    .total_errors      (total_errors)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  task automatic take_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic sub_opcode_t register_function(input logic [2:0] pick);
    case (pick)
      3'd0, 3'd5: return ADD;
      3'd1, 3'd6: return SUB;
      3'd2:       return AND;
      3'd3, 3'd7: return XOR;
      default:    return OR;
    endcase
  endfunction

  function automatic opcode_t immediate_opcode(input logic [1:0] pick);
    case (pick)
      2'd1:    return OP_ORI;
      2'd2:    return OP_XORI;
      default: return OP_ADDI;
    endcase
  endfunction

  function automatic sub_opcode_t shift_function(input logic [1:0] pick);
    case (pick)
      2'd0:    return SLLI;
      2'd1:    return SRLI;
      default: return ROTRI;
    endcase
  endfunction

  // index one past the last instruction of each phase
  function automatic int phase_end(input int phase);
    case (phase)
      0:       return 32;
      1:       return 80;
      2:       return 128;
      3:       return 176;
      default: return PROGRAM_WORDS;
    endcase
  endfunction

  task automatic build_program();
    logic [31:0] fill;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] pick;
    for (int i = 0; i < PROGRAM_WORDS; i++) begin
      take_bits(32, fill);
      take_bits(5, rd);
      take_bits(5, rs1);
      take_bits(5, rs2);
      take_bits(3, pick);
      if (i < phase_end(0)) begin
        // one MOVI per register so later phases start from known values
        program_words[i] = {fill[31], OP_MOVI, 5'(i), fill[19:0]};
      end else if (i < phase_end(1)) begin
        program_words[i] = {fill[31], OP_ALU, rd[4:0], rs1[4:0], rs2[4:0], fill[9:5],
                            register_function(pick[2:0])};
      end else if (i < phase_end(2)) begin
        program_words[i] = {fill[31], immediate_opcode(pick[1:0]), rd[4:0], rs1[4:0],
                            fill[14:0]};
      end else if (i < phase_end(3)) begin
        // rs2 field doubles as the shift amount
        program_words[i] = {fill[31], OP_ALU, rd[4:0], rs1[4:0], rs2[4:0], fill[9:5],
                            shift_function(pick[1:0])};
      end else begin
        case (pick[1:0])
          2'd0:    program_words[i] = fill;
          2'd1:    program_words[i] = {fill[31], OP_ALU, rd[4:0], rs1[4:0], fill[14:0]};
          2'd2:    program_words[i] = {fill[31], immediate_opcode(pick[2:1]), rd[4:0],
                                       rs1[4:0], fill[14:0]};
          default: program_words[i] = {fill[31], OP_MOVI, rd[4:0], fill[19:0]};
        endcase
      end
    end
  endtask

  // word for the current pc, ready before the fetch edge
  always @(posedge clock) begin
    if (reset) begin
      instruction <= '0;
    end else begin
      instruction <= program_words[pc[9:2]];
    end
  end

  initial begin
    reset       = 1'b1;
    phase_done  = 1'b0;
    phase_index = '0;
    lfsr_state  = LFSR_SEED;
    build_program();
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    for (int phase = 0; phase < PHASE_COUNT; phase++) begin
      @(negedge clock);
      while (pc != phase_end(phase) * 4) @(negedge clock);
      @(posedge clock);
      phase_done  <= 1'b1;
      phase_index <= 3'(phase);
      @(posedge clock);
      phase_done  <= 1'b0;
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    $display("%0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0 && total_checks > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the program did not finish within %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: mini_core.f
+incdir+hdl
hdl/mini_core_pkg.sv
hdl/core_controller.sv
hdl/register_file.sv
hdl/alu.sv
hdl/operand_select.sv
hdl/mini_core.sv
verif/mini_core_checker.sv
verif/mini_core_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -j 0 --top-module mini_core_tb -f mini_core.f \
  > build.log 2>&1 \
  && ./obj_dir/Vmini_core_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
